/* camera_top.f */
verilog/camera_pkg.sv
verilog/pixel_window_counter.sv
verilog/camera_command_fsm.sv
verilog/image_buffer.sv
verilog/frame_metering.sv
verilog/camera_top.sv
dv/camera_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the camera testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module camera_tb \
    -f camera_top.f \
    --Mdir build \
    -o camera_sim

./build/camera_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log || ! grep -q "Finished with no errors" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation PASSED"

/* dv/camera_tb.sv */
// Camera capture testbench
`timescale 1ns/1ps
`default_nettype none

module camera_tb;

    localparam int TIMEOUT_CYCLES = 20;

    logic       clock_spi_in;
    logic       mipi_byte_reset_n;
    logic       frame_valid;
    logic       line_valid;
    logic [7:0] pixel_data;
    logic       cmd_valid;
    logic [7:0] op_code;
    logic [1:0] byte_index;
    logic [7:0] response;
    logic       response_valid;

    // Reference model state
    camera_pkg::capture_state_e model_state;
    int                         model_ptr;
    logic [7:0]                 model_buf [camera_pkg::WINDOW_PIXELS];
    logic [7:0]                 model_avg;
    logic [7:0]                 model_min;
    logic [7:0]                 model_max;

    camera_top i_dut (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (frame_valid),
        .line_valid_i      (line_valid),
        .pixel_data_i      (pixel_data),
        .cmd_valid_i       (cmd_valid),
        .op_code_i         (op_code),
        .byte_index_i      (byte_index),
        .response_o        (response),
        .response_valid_o  (response_valid)
    );

    initial begin
        clock_spi_in = 1'b0;
        forever #4 clock_spi_in = ~clock_spi_in;
    end

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] expected,
                              input string what);
        if (got !== expected) begin
            stop_with_failure($sformatf("[ERROR] %0d ns: %s returned 0x%02h, expected 0x%02h",
                                        $time, what, got, expected));
        end
    endtask

    task automatic check_state(input camera_pkg::capture_state_e expected);
        camera_pkg::capture_state_e got;
        got = i_dut.i_camera_command_fsm.state_q;
        if (got !== expected) begin
            stop_with_failure($sformatf("[ERROR] %0d ns: capture state %s, expected %s",
                                        $time, got.name(), expected.name()));
        end
    endtask

    // Expected response and model update for one command
    task automatic predict_command(input logic [7:0] op, input logic [1:0] idx,
                                   output logic [7:0] expected, output logic known);
        logic [15:0] avail;
        expected = 8'd0;
        known    = 1'b1;
        avail    = (model_state == camera_pkg::READY) ? 16'(64 - model_ptr) : 16'd0;
        case (op)
            camera_pkg::CAPTURE: begin
                if (model_state == camera_pkg::IDLE || model_state == camera_pkg::READY) begin
                    model_state = camera_pkg::ARMED;
                    model_ptr   = 0;
                end
            end
            camera_pkg::BYTES_AVAILABLE: begin
                if (idx == 2'd0) expected = avail[15:8];
                else if (idx == 2'd1) expected = avail[7:0];
            end
            camera_pkg::READ_DATA: begin
                if (model_state == camera_pkg::READY && model_ptr < 64) begin
                    expected  = model_buf[model_ptr];
                    model_ptr = model_ptr + 1;
                end
            end
            camera_pkg::METERING: begin
                if (idx == 2'd0) expected = model_avg;
                else if (idx == 2'd1) expected = model_min;
                else if (idx == 2'd2) expected = model_max;
            end
            default: known = 1'b0;
        endcase
    endtask

    task automatic issue_command(input logic [7:0] op, input logic [1:0] idx);
        logic [7:0] expected;
        logic       known;
        int         cycles;
        predict_command(op, idx, expected, known);
        @(posedge clock_spi_in);
        #1;
        cmd_valid  = 1'b1;
        op_code    = op;
        byte_index = idx;
        @(posedge clock_spi_in);
        #1;
        cmd_valid = 1'b0;
        cycles    = 1;
        if (!known) begin
            // Unknown opcodes stay silent
            repeat (3) begin
                if (response_valid) begin
                    stop_with_failure($sformatf("[ERROR] %0d ns: response to unknown opcode 0x%02h",
                                                $time, op));
                end
                @(posedge clock_spi_in);
                #1;
            end
        end else begin
            while (!response_valid && cycles < TIMEOUT_CYCLES) begin
                @(posedge clock_spi_in);
                #1;
                cycles++;
            end
            if (!response_valid) begin
                stop_with_failure($sformatf("Timed out waiting for a response to opcode 0x%02h",
                                            op));
            end
            if (cycles != 1) begin
                stop_with_failure($sformatf("[ERROR] %0d ns: response after %0d cycles, expected 1",
                                            $time, cycles));
            end
            check_byte(response, expected, $sformatf("opcode 0x%02h index %0d", op, idx));
        end
    endtask

    // Two strobes on consecutive cycles
    task automatic issue_pair(input logic [7:0] op_a, input logic [1:0] idx_a,
                              input logic [7:0] op_b, input logic [1:0] idx_b);
        logic [7:0] exp_a;
        logic [7:0] exp_b;
        logic       known_a;
        logic       known_b;
        predict_command(op_a, idx_a, exp_a, known_a);
        predict_command(op_b, idx_b, exp_b, known_b);
        @(posedge clock_spi_in);
        #1;
        cmd_valid  = 1'b1;
        op_code    = op_a;
        byte_index = idx_a;
        @(posedge clock_spi_in);
        #1;
        if (response_valid !== known_a) begin
            stop_with_failure($sformatf(
                "[ERROR] %0d ns: response strobe %b after first strobe, expected %b",
                $time, response_valid, known_a));
        end
        if (known_a) begin
            check_byte(response, exp_a, "first strobe of pair");
        end
        op_code    = op_b;
        byte_index = idx_b;
        @(posedge clock_spi_in);
        #1;
        cmd_valid = 1'b0;
        if (response_valid !== known_b) begin
            stop_with_failure($sformatf(
                "[ERROR] %0d ns: response strobe %b after second strobe, expected %b",
                $time, response_valid, known_b));
        end
        if (known_b) begin
            check_byte(response, exp_b, "second strobe of pair");
        end
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clock_spi_in);
            #1;
            line_valid = 1'b0;
        end
    endtask

    // 12 lines of 16 pixels with the model following the window
    task automatic run_frame();
        logic store;
        int   sum;
        int   idx;
        sum       = 0;
        model_min = 8'hff;
        model_max = 8'h00;
        @(posedge clock_spi_in);
        #1;
        frame_valid = 1'b1;
        if (model_state == camera_pkg::ARMED) model_state = camera_pkg::CAPTURING;
        store = (model_state == camera_pkg::CAPTURING);
        for (int line = 0; line < 12; line++) begin
            idle_cycles(1 + $urandom_range(2));
            for (int col = 0; col < 16; col++) begin
                @(posedge clock_spi_in);
                #1;
                line_valid = 1'b1;
                pixel_data = 8'($urandom);
                if (col >= int'(camera_pkg::CROP_X_START) && col < int'(camera_pkg::CROP_X_END) &&
                    line >= int'(camera_pkg::CROP_Y_START) &&
                    line < int'(camera_pkg::CROP_Y_END)) begin
                    idx = (line - int'(camera_pkg::CROP_Y_START)) *
                          int'(camera_pkg::CROP_X_END - camera_pkg::CROP_X_START) +
                          (col - int'(camera_pkg::CROP_X_START));
                    sum = sum + pixel_data;
                    if (pixel_data < model_min) model_min = pixel_data;
                    if (pixel_data > model_max) model_max = pixel_data;
                    if (store) model_buf[idx] = pixel_data;
                end
            end
        end
        idle_cycles(1 + $urandom_range(2));
        @(posedge clock_spi_in);
        #1;
        frame_valid = 1'b0;
        model_avg   = 8'(sum >> camera_pkg::METER_SHIFT);
        if (model_state == camera_pkg::CAPTURING) model_state = camera_pkg::READY;
        idle_cycles(2 + $urandom_range(3));
    endtask

    task automatic check_metering();
        for (int i = 0; i < 4; i++) begin
            issue_command(camera_pkg::METERING, 2'(i));
        end
    endtask

    task automatic check_available();
        issue_command(camera_pkg::BYTES_AVAILABLE, 2'd0);
        issue_command(camera_pkg::BYTES_AVAILABLE, 2'd1);
    endtask

    initial begin
        void'($urandom(66750));
        mipi_byte_reset_n = 1'b0;
        frame_valid       = 1'b0;
        line_valid        = 1'b0;
        pixel_data        = 8'd0;
        cmd_valid         = 1'b0;
        op_code           = 8'd0;
        byte_index        = 2'd0;
        model_state       = camera_pkg::IDLE;
        model_ptr         = 0;
        model_avg         = 8'd0;
        model_min         = 8'd0;
        model_max         = 8'd0;
        repeat (4) @(posedge clock_spi_in);
        #1;
        mipi_byte_reset_n = 1'b1;

        check_state(camera_pkg::IDLE);
        check_metering();
        check_available();
        repeat (2) begin
            run_frame();
            check_metering();
        end

        // Capture one frame with nothing readable until it ends
        issue_command(camera_pkg::CAPTURE, 2'd0);
        check_state(camera_pkg::ARMED);
        check_available();
        fork
            run_frame();
            begin
                repeat (40) @(posedge clock_spi_in);
                check_available();
                issue_command(camera_pkg::CAPTURE, 2'd0);
                check_state(camera_pkg::CAPTURING);
            end
        join
        check_state(camera_pkg::READY);
        check_available();
        check_metering();
        for (int i = 0; i < 66; i++) begin
            issue_command(camera_pkg::READ_DATA, 2'd0);
            check_available();
        end

        // Capture armed mid-frame waits for the next frame
        fork
            run_frame();
            begin
                repeat (40) @(posedge clock_spi_in);
                issue_command(camera_pkg::CAPTURE, 2'd0);
                check_state(camera_pkg::ARMED);
            end
        join
        check_state(camera_pkg::ARMED);
        check_metering();
        issue_command(camera_pkg::CAPTURE, 2'd0);
        run_frame();
        check_metering();
        run_frame();
        check_state(camera_pkg::READY);
        check_metering();
        for (int i = 0; i < 64; i++) begin
            issue_command(camera_pkg::READ_DATA, 2'd0);
        end
        check_available();

        // Back-to-back strobes and unknown opcodes
        issue_pair(camera_pkg::METERING, 2'd0, camera_pkg::BYTES_AVAILABLE, 2'd1);
        issue_pair(camera_pkg::CAPTURE, 2'd0, camera_pkg::METERING, 2'd2);
        issue_pair(camera_pkg::BYTES_AVAILABLE, 2'd0, camera_pkg::READ_DATA, 2'd0);
        issue_pair(8'h33, 2'd0, camera_pkg::METERING, 2'd1);
        issue_command(8'h33, 2'd0);
        issue_command(8'h00, 2'd1);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/camera_top.sv */
// Camera command and capture top level
`timescale 1ns/1ps
`default_nettype none

module camera_top (
    input  wire logic       clock_spi_in,
    input  wire logic       mipi_byte_reset_n,
    input  wire logic       frame_valid_i,
    input  wire logic       line_valid_i,
    input  wire logic [7:0] pixel_data_i,
    input  wire logic       cmd_valid_i,
    input  wire logic [7:0] op_code_i,
    input  wire logic [1:0] byte_index_i,
    output logic [7:0]      response_o,
    output logic            response_valid_o
);

    logic                          frame_start;
    logic                          frame_end;
    logic                          in_window;
    logic [camera_pkg::ADDR_W-1:0] window_index;
    logic                          capture_write;
    logic [camera_pkg::ADDR_W-1:0] read_address;
    logic [7:0]                    read_data;
    logic [7:0]                    meter_avg;
    logic [7:0]                    meter_min;
    logic [7:0]                    meter_max;

    pixel_window_counter i_pixel_window_counter (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_valid_i     (frame_valid_i),
        .line_valid_i      (line_valid_i),
        .frame_start_o     (frame_start),
        .frame_end_o       (frame_end),
        .in_window_o       (in_window),
        .window_index_o    (window_index)
    );

    camera_command_fsm i_camera_command_fsm (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .cmd_valid_i       (cmd_valid_i),
        .op_code_i         (op_code_i),
        .byte_index_i      (byte_index_i),
        .frame_start_i     (frame_start),
        .frame_end_i       (frame_end),
        .in_window_i       (in_window),
        .read_data_i       (read_data),
        .meter_avg_i       (meter_avg),
        .meter_min_i       (meter_min),
        .meter_max_i       (meter_max),
        .capture_write_o   (capture_write),
        .read_address_o    (read_address),
        .response_o        (response_o),
        .response_valid_o  (response_valid_o)
    );

    image_buffer i_image_buffer (
        .clock_spi_in      (clock_spi_in),
        .write_enable_i    (capture_write),
        .write_address_i   (window_index),
        .write_data_i      (pixel_data_i),
        .read_address_i    (read_address),
        .read_data_o       (read_data)
    );

    frame_metering i_frame_metering (
        .clock_spi_in      (clock_spi_in),
        .mipi_byte_reset_n (mipi_byte_reset_n),
        .frame_start_i     (frame_start),
        .frame_end_i       (frame_end),
        .in_window_i       (in_window),
        .pixel_data_i      (pixel_data_i),
        .meter_avg_o       (meter_avg),
        .meter_min_o       (meter_min),
        .meter_max_o       (meter_max)
    );

endmodule

`default_nettype wire

/* verilog/frame_metering.sv */
// Window brightness statistics
`timescale 1ns/1ps
`default_nettype none

module frame_metering (
    input  wire logic       clock_spi_in,
    input  wire logic       mipi_byte_reset_n,
    input  wire logic       frame_start_i,
    input  wire logic       frame_end_i,
    input  wire logic       in_window_i,
    input  wire logic [7:0] pixel_data_i,
    output logic [7:0]      meter_avg_o,
    output logic [7:0]      meter_min_o,
    output logic [7:0]      meter_max_o
);

    // Wide enough for 64 full-scale pixels
    logic [camera_pkg::ADDR_W+7:0] sum_q;
    logic [7:0]                    min_q;
    logic [7:0]                    max_q;

    // Running statistics for the frame in progress
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            sum_q <= '0;
            min_q <= 8'hff;
            max_q <= 8'h00;
        end else if (frame_start_i) begin
            sum_q <= '0;
            min_q <= 8'hff;
            max_q <= 8'h00;
        end else if (in_window_i) begin
            sum_q <= sum_q + (camera_pkg::ADDR_W+8)'(pixel_data_i);
            if (pixel_data_i < min_q) begin
                min_q <= pixel_data_i;
            end
            if (pixel_data_i > max_q) begin
                max_q <= pixel_data_i;
            end
        end
    end

    // Results held from one frame end to the next
    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            meter_avg_o <= 8'd0;
            meter_min_o <= 8'd0;
            meter_max_o <= 8'd0;
        end else if (frame_end_i) begin
            meter_avg_o <= 8'(sum_q >> camera_pkg::METER_SHIFT);
            meter_min_o <= min_q;
            meter_max_o <= max_q;
        end
    end

endmodule

`default_nettype wire

/* verilog/image_buffer.sv */
// Capture window memory
`timescale 1ns/1ps
`default_nettype none

module image_buffer (
    input  wire logic                          clock_spi_in,
    input  wire logic                          write_enable_i,
    input  wire logic [camera_pkg::ADDR_W-1:0] write_address_i,
    input  wire logic [7:0]                    write_data_i,
    input  wire logic [camera_pkg::ADDR_W-1:0] read_address_i,
    output logic [7:0]                         read_data_o
);

    // One byte per window pixel
    logic [7:0] mem [camera_pkg::WINDOW_PIXELS];

    always_ff @(posedge clock_spi_in) begin
        if (write_enable_i) begin
            mem[write_address_i] <= write_data_i;
        end
    end

    // Read is combinational so a response can use it in the same cycle
    assign read_data_o = mem[read_address_i];

endmodule

`default_nettype wire

/* verilog/camera_command_fsm.sv */
// Capture control and command responses
`timescale 1ns/1ps
`default_nettype none

module camera_command_fsm (
    input  wire logic                          clock_spi_in,
    input  wire logic                          mipi_byte_reset_n,
    input  wire logic                          cmd_valid_i,
    input  wire logic [7:0]                    op_code_i,
    input  wire logic [1:0]                    byte_index_i,
    input  wire logic                          frame_start_i,
    input  wire logic                          frame_end_i,
    input  wire logic                          in_window_i,
    input  wire logic [7:0]                    read_data_i,
    input  wire logic [7:0]                    meter_avg_i,
    input  wire logic [7:0]                    meter_min_i,
    input  wire logic [7:0]                    meter_max_i,
    output logic                               capture_write_o,
    output logic [camera_pkg::ADDR_W-1:0]      read_address_o,
    output logic [7:0]                         response_o,
    output logic                               response_valid_o
);

    camera_pkg::capture_state_e    state_q;
    camera_pkg::capture_state_e    state_d;
    logic [camera_pkg::ADDR_W:0]   read_ptr_q;
    logic [camera_pkg::ADDR_W:0]   read_ptr_d;
    logic [15:0]                   unread_count;
    logic [7:0]                    response_d;
    logic                          response_valid_d;

    // Only the frame being captured reaches the buffer
    assign capture_write_o = in_window_i && (state_q == camera_pkg::CAPTURING);
    assign read_address_o  = read_ptr_q[camera_pkg::ADDR_W-1:0];

    assign unread_count = (state_q == camera_pkg::READY) ?
        16'(camera_pkg::WINDOW_PIXELS) - 16'(read_ptr_q) : 16'd0;

    always_comb begin
        state_d          = state_q;
        read_ptr_d       = read_ptr_q;
        response_d       = 8'd0;
        response_valid_d = 1'b0;

        // Frame events only matter once armed
        case (state_q)
            camera_pkg::ARMED: begin
                if (frame_start_i) begin
                    state_d = camera_pkg::CAPTURING;
                end
            end
            camera_pkg::CAPTURING: begin
                if (frame_end_i) begin
                    state_d = camera_pkg::READY;
                end
            end
            default: begin
            end
        endcase

        if (cmd_valid_i) begin
            case (camera_pkg::opcode_e'(op_code_i))
                camera_pkg::CAPTURE: begin
                    response_valid_d = 1'b1;
                    if (state_q == camera_pkg::IDLE || state_q == camera_pkg::READY) begin
                        state_d    = camera_pkg::ARMED;
                        read_ptr_d = '0;
                    end
                end
                camera_pkg::BYTES_AVAILABLE: begin
                    response_valid_d = 1'b1;
                    case (byte_index_i)
                        2'd0:    response_d = unread_count[15:8];
                        2'd1:    response_d = unread_count[7:0];
                        default: response_d = 8'd0;
                    endcase
                end
                camera_pkg::READ_DATA: begin
                    response_valid_d = 1'b1;
                    // Top pointer bit set means all 64 bytes are read
                    if (state_q == camera_pkg::READY && !read_ptr_q[camera_pkg::ADDR_W]) begin
                        response_d = read_data_i;
                        read_ptr_d = read_ptr_q + 1'b1;
                    end
                end
                camera_pkg::METERING: begin
                    response_valid_d = 1'b1;
                    case (byte_index_i)
                        2'd0:    response_d = meter_avg_i;
                        2'd1:    response_d = meter_min_i;
                        2'd2:    response_d = meter_max_i;
                        default: response_d = 8'd0;
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state_q          <= camera_pkg::IDLE;
            read_ptr_q       <= '0;
            response_o       <= 8'd0;
            response_valid_o <= 1'b0;
        end else begin
            state_q          <= state_d;
            read_ptr_q       <= read_ptr_d;
            response_valid_o <= response_valid_d;
            // Last response byte holds between commands
            if (response_valid_d) begin
                response_o <= response_d;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/pixel_window_counter.sv */
// Pixel position and crop window tracking
`timescale 1ns/1ps
`default_nettype none

module pixel_window_counter (
    input  wire logic                          clock_spi_in,
    input  wire logic                          mipi_byte_reset_n,
    input  wire logic                          frame_valid_i,
    input  wire logic                          line_valid_i,
    output logic                               frame_start_o,
    output logic                               frame_end_o,
    output logic                               in_window_o,
    output logic [camera_pkg::ADDR_W-1:0]      window_index_o
);

    logic                            frame_valid_q;
    logic                            line_valid_q;
    logic                            pixel_valid;
    logic                            frame_rise;
    logic                            frame_fall;
    logic                            line_end;
    logic [camera_pkg::COUNT_W-1:0]  col_count;
    logic [camera_pkg::COUNT_W-1:0]  line_count;
    logic [camera_pkg::COUNT_W-1:0]  col_off;
    logic [camera_pkg::COUNT_W-1:0]  row_off;
    logic                            col_in;
    logic                            row_in;

    assign pixel_valid = frame_valid_i & line_valid_i;
    assign frame_rise  = frame_valid_i & ~frame_valid_q;
    assign frame_fall  = ~frame_valid_i & frame_valid_q;
    assign line_end    = ~line_valid_i & line_valid_q;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            frame_valid_q <= 1'b0;
            line_valid_q  <= 1'b0;
            frame_start_o <= 1'b0;
            frame_end_o   <= 1'b0;
            col_count     <= '0;
            line_count    <= '0;
        end else begin
            frame_valid_q <= frame_valid_i;
            line_valid_q  <= line_valid_i;
            // Edge pulses land one cycle after the edge is seen
            frame_start_o <= frame_rise;
            frame_end_o   <= frame_fall;

            if (line_end) begin
                col_count <= '0;
            end else if (pixel_valid) begin
                col_count <= col_count + 1'b1;
            end

            if (frame_rise) begin
                line_count <= '0;
            end else if (line_end) begin
                line_count <= line_count + 1'b1;
            end
        end
    end

    // Window test on the current pixel
    assign col_in = (col_count >= camera_pkg::CROP_X_START) &&
                    (col_count < camera_pkg::CROP_X_END);
    assign row_in = (line_count >= camera_pkg::CROP_Y_START) &&
                    (line_count < camera_pkg::CROP_Y_END);
    assign in_window_o = pixel_valid & col_in & row_in;

    // Row-major index, only meaningful inside the window
    assign col_off = col_count - camera_pkg::CROP_X_START;
    assign row_off = line_count - camera_pkg::CROP_Y_START;
    assign window_index_o = camera_pkg::ADDR_W'(
        row_off * (camera_pkg::CROP_X_END - camera_pkg::CROP_X_START) + col_off);

endmodule

`default_nettype wire

/* verilog/camera_pkg.sv */
// Camera capture shared definitions
`default_nettype none

package camera_pkg;

    // Command opcodes, kept from the camera command set
    typedef enum logic [7:0] {
        CAPTURE         = 8'h20,
        BYTES_AVAILABLE = 8'h21,
        READ_DATA       = 8'h22,
        METERING        = 8'h25
    } opcode_e;

    // Capture progress
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        ARMED     = 2'd1,
        CAPTURING = 2'd2,
        READY     = 2'd3
    } capture_state_e;

    // Width of the column and line counters
    localparam int COUNT_W = 11;

    // Fixed crop window, end bounds exclusive
    localparam logic [COUNT_W-1:0] CROP_X_START = COUNT_W'(4);
    localparam logic [COUNT_W-1:0] CROP_X_END   = COUNT_W'(12);
    localparam logic [COUNT_W-1:0] CROP_Y_START = COUNT_W'(2);
    localparam logic [COUNT_W-1:0] CROP_Y_END   = COUNT_W'(10);

    // Window size and buffer addressing
    localparam int WINDOW_PIXELS = 64;
    localparam int ADDR_W        = 6;

    // Sum of 64 pixels down to an 8-bit average
    localparam int METER_SHIFT = 6;

endpackage

`default_nettype wire
